//--- project.f
+incdir+.
usiPkg.sv
UsiBusMaster.sv
MicroControllerCsr.sv
RamWriteEngine.sv
UsiRamSubsystem.sv
tbUsiRamChecker.sv
tbUsiRamSubsystem.sv

//--- Bender.yml
package:
  name: usi_ram_subsystem

sources:
  - include_dirs:
      - .
    files:
      - usiPkg.sv
      - UsiBusMaster.sv
      - MicroControllerCsr.sv
      - RamWriteEngine.sv
      - UsiRamSubsystem.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbUsiRamChecker.sv
      - tbUsiRamSubsystem.sv

//--- tbUsiRamSubsystem.sv
`timescale 1ns/1ps

`include "usiRam_params.svh"

module tbUsiRamSubsystem;

	import usiPkg::*;

	localparam int NUM_REG_LOOPS = 8;
	localparam int NUM_UNMAPPED = 8;
	localparam int NUM_RAM_LOOPS = 4;
	// Reset reads, register loops, unmapped loops plus readback, RAM loops
	localparam int NUM_CMDS = 4 + 6 * NUM_REG_LOOPS + 2 * NUM_UNMAPPED + 3 + 7 * NUM_RAM_LOOPS;
	localparam int WATCHDOG_CYCLES = NUM_CMDS * 10 + 200;

	logic iSCLK;
	logic iSRST;
	logic cmdValid;
	cmdKindT cmdKind;
	logic [15:0] cmdOfs;
	logic [`USI_BUS_WIDTH-1:0] cmdWd;
	logic rspValid;
	logic [`USI_BUS_WIDTH-1:0] rspRd;
	logic [`MEM_ADRS_BITS-1:0] memRdAdrs;
	logic [`RAM_WD_WIDTH-1:0] memRd;
	int errCount;
	int checkCount;
	int pendCount;

	UsiRamSubsystem i_UsiRamSubsystem
	(
		.iSCLK (iSCLK),
		.iSRST (iSRST),
		.cmdValid (cmdValid),
		.cmdKind (cmdKind),
		.cmdOfs (cmdOfs),
		.cmdWd (cmdWd),
		.rspValid (rspValid),
		.rspRd (rspRd),
		.memRdAdrs (memRdAdrs),
		.memRd (memRd)
	);

	tbUsiRamChecker i_tbUsiRamChecker
	(
		.iSCLK (iSCLK),
		.iSRST (iSRST),
		.cmdValid (cmdValid),
		.cmdKind (cmdKind),
		.cmdOfs (cmdOfs),
		.cmdWd (cmdWd),
		.rspValid (rspValid),
		.rspRd (rspRd),
		.memRdAdrs (memRdAdrs),
		.memRd (memRd),
		.errCount (errCount),
		.checkCount (checkCount),
		.pendCount (pendCount)
	);

	// 8 ns clock
	initial
	begin
		iSCLK = 1'b0;
		forever
		begin
			#4;
			iSCLK = ~iSCLK;
		end
	end

	// --------------------------------------------------
	// Host command tasks
	// --------------------------------------------------

	// One-cycle strobe, then 4 idle cycles
	task automatic issueCmd(input cmdKindT kind, input logic [15:0] ofs,
		input logic [`USI_BUS_WIDTH-1:0] wd);
		cmdValid = 1'b1;
		cmdKind = kind;
		cmdOfs = ofs;
		cmdWd = wd;
		@(posedge iSCLK);
		#1;
		cmdValid = 1'b0;
		cmdKind = CMD_READ;
		cmdOfs = '0;
		cmdWd = '0;
		repeat (4) @(posedge iSCLK);
		#1;
	endtask

	// Reads carry random data for the pass-through
	task automatic readReg(input logic [15:0] ofs);
		issueCmd(CMD_READ, ofs, $urandom);
	endtask

	task automatic idleCycles(input int n);
		repeat (n) @(posedge iSCLK);
		#1;
	endtask

	// Checker compares memRd once it is registered
	task automatic debugRead(input logic [`MEM_ADRS_BITS-1:0] adrs);
		memRdAdrs = adrs;
		idleCycles(2);
	endtask

	// Offset that no register write decodes
	function automatic logic [15:0] pickUnmappedOfs(input int i, input logic [15:0] r);
		logic [7:0] low;
		// Register low byte reused on odd loops
		case ((i / 2) % 3)
			0: low = 8'(`CSR_OFS_RAM_WD);
			1: low = 8'(`CSR_OFS_RAM_ADRS);
			default: low = 8'(`CSR_OFS_RAM_EN);
		endcase
		// Nonzero high byte, only the full offset tells it apart
		if (i % 2 == 1)
			return {r[15:8] | 8'h01, low};
		if (r == `CSR_OFS_RAM_WD || r == `CSR_OFS_RAM_ADRS || r == `CSR_OFS_RAM_EN)
			return r ^ 16'h0100;
		return r;
	endfunction

	// --------------------------------------------------
	// Stimulus
	// --------------------------------------------------
	initial
	begin
		logic [`USI_BUS_WIDTH-1:0] data;
		logic [`USI_BUS_WIDTH-1:0] adrs;
		logic [15:0] ofs;
		void'($urandom(32'h89a9));
		iSRST = 1'b1;
		cmdValid = 1'b0;
		cmdKind = CMD_READ;
		cmdOfs = '0;
		cmdWd = '0;
		memRdAdrs = '0;
		repeat (4) @(posedge iSCLK);
		#1;
		iSRST = 1'b0;
		idleCycles(2);
		// Reset values, status idle
		readReg(`CSR_OFS_RAM_WD);
		readReg(`CSR_OFS_RAM_ADRS);
		readReg(`CSR_OFS_RAM_EN);
		readReg(`CSR_OFS_RAM_RDY);
		// Random register readback
		for (int i = 0; i < NUM_REG_LOOPS; i++)
		begin
			issueCmd(CMD_WRITE, `CSR_OFS_RAM_WD, $urandom);
			issueCmd(CMD_WRITE, `CSR_OFS_RAM_ADRS, $urandom);
			issueCmd(CMD_WRITE, `CSR_OFS_RAM_EN, $urandom);
			readReg(`CSR_OFS_RAM_WD);
			readReg(`CSR_OFS_RAM_ADRS);
			readReg(`CSR_OFS_RAM_EN);
		end
		// Unmapped writes and pass-through reads
		for (int i = 0; i < NUM_UNMAPPED; i++)
		begin
			ofs = pickUnmappedOfs(i, 16'($urandom));
			issueCmd(CMD_WRITE, ofs, $urandom);
			readReg(ofs);
		end
		// Mapped registers must be untouched
		readReg(`CSR_OFS_RAM_WD);
		readReg(`CSR_OFS_RAM_ADRS);
		readReg(`CSR_OFS_RAM_EN);
		// RAM writes with status before and after
		for (int i = 0; i < NUM_RAM_LOOPS; i++)
		begin
			data = $urandom;
			adrs = $urandom;
			issueCmd(CMD_WRITE, `CSR_OFS_RAM_EN, 32'h0);
			issueCmd(CMD_WRITE, `CSR_OFS_RAM_WD, data);
			issueCmd(CMD_WRITE, `CSR_OFS_RAM_ADRS, adrs);
			issueCmd(CMD_WRITE, `CSR_OFS_RAM_EN, 32'h1);
			// Still busy here
			readReg(`CSR_OFS_RAM_RDY);
			idleCycles(8);
			readReg(`CSR_OFS_RAM_RDY);
			debugRead(adrs[`MEM_ADRS_BITS-1:0]);
			issueCmd(CMD_WRITE, `CSR_OFS_RAM_EN, 32'h0);
		end
		idleCycles(8);
		$display("Errors %0d, checks %0d, pending reads %0d", errCount, checkCount, pendCount);
		if (errCount == 0 && pendCount == 0 && checkCount > 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	// Watchdog
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge iSCLK);
		$display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Errors %0d, checks %0d, pending reads %0d", errCount, checkCount, pendCount);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- tbUsiRamChecker.sv
`timescale 1ns/1ps

`include "usiRam_params.svh"

module tbUsiRamChecker
(
	input logic iSCLK,
	input logic iSRST,
	// Host side of the DUT
	input logic cmdValid,
	input usiPkg::cmdKindT cmdKind,
	input logic [15:0] cmdOfs,
	input logic [`USI_BUS_WIDTH-1:0] cmdWd,
	input logic rspValid,
	input logic [`USI_BUS_WIDTH-1:0] rspRd,
	// Memory debug port
	input logic [`MEM_ADRS_BITS-1:0] memRdAdrs,
	input logic [`RAM_WD_WIDTH-1:0] memRd,
	// Totals for the closing line
	output int errCount,
	output int checkCount,
	output int pendCount
);

	import usiPkg::*;

	// CSR register model
	logic [`RAM_WD_WIDTH-1:0] modelWd;
	logic [`RAM_ADRS_WIDTH-1:0] modelAdrs;
	logic modelEn;
	// Memory model, only written words are known
	logic [`RAM_WD_WIDTH-1:0] modelMem [0:(1 << `MEM_ADRS_BITS)-1];
	logic [(1 << `MEM_ADRS_BITS)-1:0] memKnown;
	// Edge counter, edge of the last enable strobe that started a write
	int cyc;
	int enStart;
	// Memory write in flight
	logic wrPend;
	int wrDue;
	logic [`RAM_WD_WIDTH-1:0] wrData;
	logic [`MEM_ADRS_BITS-1:0] wrAdrs;
	// Expected responses and their arrival edges
	logic [`USI_BUS_WIDTH-1:0] expQ [$];
	int dueQ [$];
	// Debug read sampled on the previous edge
	logic memExpValid;
	logic [`RAM_WD_WIDTH-1:0] memExp;

	// --------------------------------------------------
	// Reference model
	// --------------------------------------------------

	// Read answer for a strobe seen at edge strobeCyc
	function automatic logic [`USI_BUS_WIDTH-1:0] expectRead(input logic [15:0] ofs,
		input logic [`USI_BUS_WIDTH-1:0] wd, input int strobeCyc);
		logic [`CSR_READ_BITS-1:0] low;
		logic busySeen;
		low = ofs[`CSR_READ_BITS-1:0];
		// Engine busy from two edges after the strobe, status one edge late
		busySeen = (strobeCyc >= enStart + 3) &&
			(strobeCyc <= enStart + 2 + `RAM_WRITE_CYCLES);
		if (low == `CSR_READ_BITS'(`CSR_OFS_RAM_WD))
			return `USI_BUS_WIDTH'(modelWd);
		if (low == `CSR_READ_BITS'(`CSR_OFS_RAM_ADRS))
			return `USI_BUS_WIDTH'(modelAdrs);
		if (low == `CSR_READ_BITS'(`CSR_OFS_RAM_EN))
			return `USI_BUS_WIDTH'(modelEn);
		if (low == `CSR_READ_BITS'(`CSR_OFS_RAM_RDY))
			return `USI_BUS_WIDTH'(!busySeen);
		// Chain pass-through
		return wd;
	endfunction

	// Register writes decode the full offset
	task automatic applyWrite(input logic [15:0] ofs, input logic [`USI_BUS_WIDTH-1:0] wd);
		if (ofs == `CSR_OFS_RAM_WD)
			modelWd = wd[`RAM_WD_WIDTH-1:0];
		else if (ofs == `CSR_OFS_RAM_ADRS)
			modelAdrs = wd[`RAM_ADRS_WIDTH-1:0];
		else if (ofs == `CSR_OFS_RAM_EN)
		begin
			// Rising enable takes data and address as they are now
			if (wd[0] && !modelEn)
			begin
				enStart = cyc;
				wrPend = 1'b1;
				wrDue = cyc + 2 + `RAM_WRITE_CYCLES;
				wrData = modelWd;
				wrAdrs = modelAdrs[`MEM_ADRS_BITS-1:0];
			end
			modelEn = wd[0];
		end
	endtask

	// --------------------------------------------------
	// Comparisons
	// --------------------------------------------------
	always @(posedge iSCLK)
	begin
		logic [`USI_BUS_WIDTH-1:0] expRd;
		int expDue;
		if (iSRST)
		begin
			modelWd = '0;
			modelAdrs = '0;
			modelEn = 1'b0;
			memKnown = '0;
			enStart = -100;
			wrPend = 1'b0;
			memExpValid = 1'b0;
			expQ.delete();
			dueQ.delete();
			errCount = 0;
			checkCount = 0;
		end
		else
		begin
			// Read responses, in order
			if (rspValid)
			begin
				if (expQ.size() == 0)
				begin
					$display("Read response %h arrived with no read pending at %0t", rspRd, $time);
					errCount++;
				end
				else
				begin
					expRd = expQ.pop_front();
					expDue = dueQ.pop_front();
					checkCount++;
					if (rspRd !== expRd)
					begin
						$display("CHECK FAILED rspRd: expected %h, actual %h", expRd, rspRd);
						errCount++;
					end
					if (cyc != expDue)
					begin
						$display("Read response came at edge %0d instead of %0d", cyc, expDue);
						errCount++;
					end
				end
			end
			else if (dueQ.size() > 0 && cyc > dueQ[0])
			begin
				$display("Read response missing, it was due at edge %0d", dueQ[0]);
				errCount++;
				void'(expQ.pop_front());
				void'(dueQ.pop_front());
			end
			// Debug read registered on the previous edge
			if (memExpValid)
			begin
				checkCount++;
				if (memRd !== memExp)
				begin
					$display("CHECK FAILED memRd: expected %h, actual %h", memExp, memRd);
					errCount++;
				end
			end
			// Old contents when read and write share an edge
			memExpValid = memKnown[memRdAdrs];
			memExp = modelMem[memRdAdrs];
			if (wrPend && cyc == wrDue)
			begin
				modelMem[wrAdrs] = wrData;
				memKnown[wrAdrs] = 1'b1;
				wrPend = 1'b0;
			end
			// New command from the host
			if (cmdValid)
			begin
				if (cmdKind == CMD_WRITE)
					applyWrite(cmdOfs, cmdWd);
				else
				begin
					expQ.push_back(expectRead(cmdOfs, cmdWd, cyc));
					dueQ.push_back(cyc + 3);
				end
			end
		end
		cyc++;
		pendCount = expQ.size();
	end

	initial
	begin
		cyc = 0;
	end

endmodule

//--- UsiRamSubsystem.sv
`timescale 1ns/1ps

`include "usiRam_params.svh"

module UsiRamSubsystem
(
	input logic iSCLK,
	input logic iSRST,
	// Host commands
	input logic cmdValid,
	input usiPkg::cmdKindT cmdKind,
	input logic [15:0] cmdOfs,
	input logic [`USI_BUS_WIDTH-1:0] cmdWd,
	// Read responses
	output logic rspValid,
	output logic [`USI_BUS_WIDTH-1:0] rspRd,
	// Memory debug port
	input logic [`MEM_ADRS_BITS-1:0] memRdAdrs,
	output logic [`RAM_WD_WIDTH-1:0] memRd
);

	import usiPkg::*;

	// USI bus
	usiAdrsU usiAdrs;
	logic [`USI_BUS_WIDTH-1:0] usiWd;
	logic [`USI_BUS_WIDTH-1:0] usiRd;

	// CSR to engine
	logic [`RAM_WD_WIDTH-1:0] ramWd;
	logic [`RAM_ADRS_WIDTH-1:0] ramAdrs;
	logic ramEn;
	logic ramRdy;

	// ------------------------------------------------
	// Bus master
	// ------------------------------------------------
	UsiBusMaster i_UsiBusMaster
	(
		.iSCLK (iSCLK),
		.iSRST (iSRST),
		.cmdValid (cmdValid),
		.cmdKind (cmdKind),
		.cmdOfs (cmdOfs),
		.cmdWd (cmdWd),
		.usiAdrs (usiAdrs),
		.usiWd (usiWd),
		.usiRd (usiRd),
		.rspValid (rspValid),
		.rspRd (rspRd)
	);

	// CSR block on the bus
	MicroControllerCsr i_MicroControllerCsr
	(
		.iSCLK (iSCLK),
		.iSRST (iSRST),
		.usiAdrs (usiAdrs),
		.usiWd (usiWd),
		.usiRd (usiRd),
		.ramWd (ramWd),
		.ramAdrs (ramAdrs),
		.ramEn (ramEn),
		.ramRdy (ramRdy)
	);

	// Memory and its write engine
	RamWriteEngine i_RamWriteEngine
	(
		.iSCLK (iSCLK),
		.iSRST (iSRST),
		.ramWd (ramWd),
		.ramAdrs (ramAdrs),
		.ramEn (ramEn),
		.ramRdy (ramRdy),
		.memRdAdrs (memRdAdrs),
		.memRd (memRd)
	);

endmodule

//--- RamWriteEngine.sv
`timescale 1ns/1ps

`include "usiRam_params.svh"

module RamWriteEngine
(
	input logic iSCLK,
	input logic iSRST,
	// CSR registers
	input logic [`RAM_WD_WIDTH-1:0] ramWd,
	input logic [`RAM_ADRS_WIDTH-1:0] ramAdrs,
	input logic ramEn,
	// High while idle
	output logic ramRdy,
	// Debug read port
	input logic [`MEM_ADRS_BITS-1:0] memRdAdrs,
	output logic [`RAM_WD_WIDTH-1:0] memRd
);

	// Counter wide enough for the busy time
	localparam int CNT_BITS = $clog2(`RAM_WRITE_CYCLES + 1);
	localparam int MEM_DEPTH = 1 << `MEM_ADRS_BITS;

	// Memory array
	logic [`RAM_WD_WIDTH-1:0] mem [0:MEM_DEPTH-1];

	// Enable of the previous cycle
	logic ramEnPrev;
	// New write request
	logic startWr;
	// Latched write payload
	logic [`RAM_WD_WIDTH-1:0] wrData;
	logic [`MEM_ADRS_BITS-1:0] wrAdrs;
	// Remaining busy cycles minus one
	logic [CNT_BITS-1:0] busyCnt;

	// Rising edge, ignored while busy
	assign startWr = ramEn & ~ramEnPrev & ramRdy;

	// ------------------------------------------------
	// Busy control
	// ------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			ramEnPrev <= 1'b0;
			ramRdy <= 1'b1;
			busyCnt <= '0;
		end
		else
		begin
			ramEnPrev <= ramEn;
			if (startWr)
			begin
				ramRdy <= 1'b0;
				busyCnt <= CNT_BITS'(`RAM_WRITE_CYCLES - 1);
			end
			else if (!ramRdy)
			begin
				// Last busy cycle ends with the write
				if (busyCnt == '0)
					ramRdy <= 1'b1;
				else
					busyCnt <= busyCnt - 1'b1;
			end
		end
	end

	// Payload captured on the start edge
	always_ff @(posedge iSCLK)
	begin
		if (startWr)
		begin
			wrData <= ramWd;
			wrAdrs <= ramAdrs[`MEM_ADRS_BITS-1:0];
		end
	end

	// ------------------------------------------------
	// Memory write and debug read
	// ------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		// Same edge that raises ramRdy
		if (!ramRdy && busyCnt == '0)
			mem[wrAdrs] <= wrData;
		// Registered read, one cycle latency
		memRd <= mem[memRdAdrs];
	end

endmodule

//--- MicroControllerCsr.sv
`timescale 1ns/1ps

`include "usiRam_params.svh"

module MicroControllerCsr
(
	input logic iSCLK,
	input logic iSRST,
	// USI bus slave side
	input usiPkg::usiAdrsU usiAdrs,
	input logic [`USI_BUS_WIDTH-1:0] usiWd,
	output logic [`USI_BUS_WIDTH-1:0] usiRd,
	// Registers towards the write engine
	output logic [`RAM_WD_WIDTH-1:0] ramWd,
	output logic [`RAM_ADRS_WIDTH-1:0] ramAdrs,
	output logic ramEn,
	// Engine status
	input logic ramRdy
);

	// Write enables per register
	logic wrWd;
	logic wrAdrs;
	logic wrEn;
	// Bus write aimed at this block
	logic wrHit;
	// Status sampled one cycle late
	logic ramRdySmp;

	// ------------------------------------------------
	// Write decode
	// ------------------------------------------------

	// Write flag and block id common to all enables
	assign wrHit = usiAdrs.fields.wrFlag & (usiAdrs.fields.blockId == `CSR_BLOCK_ID);

	// Full 16-bit offset compare
	assign wrWd = wrHit & (usiAdrs.fields.csrOfs == `CSR_OFS_RAM_WD);
	assign wrAdrs = wrHit & (usiAdrs.fields.csrOfs == `CSR_OFS_RAM_ADRS);
	assign wrEn = wrHit & (usiAdrs.fields.csrOfs == `CSR_OFS_RAM_EN);

	// ------------------------------------------------
	// Write registers and status
	// ------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			ramWd <= '0;
			ramAdrs <= '0;
			ramEn <= 1'b0;
			ramRdySmp <= 1'b0;
		end
		else
		begin
			// Low bits of the bus data only
			if (wrWd)
				ramWd <= usiWd[`RAM_WD_WIDTH-1:0];
			if (wrAdrs)
				ramAdrs <= usiWd[`RAM_ADRS_WIDTH-1:0];
			if (wrEn)
				ramEn <= usiWd[0];
			// Sampled every cycle
			ramRdySmp <= ramRdy;
		end
	end

	// ------------------------------------------------
	// Read mux
	// ------------------------------------------------

	// Decodes the low raw offset bits, no block check
	always_ff @(posedge iSCLK)
	begin
		case (usiAdrs.raw[`CSR_READ_BITS-1:0])
			`CSR_READ_BITS'(`CSR_OFS_RAM_WD):
				usiRd <= {{(`USI_BUS_WIDTH-`RAM_WD_WIDTH){1'b0}}, ramWd};
			`CSR_READ_BITS'(`CSR_OFS_RAM_ADRS):
				usiRd <= ramAdrs;
			`CSR_READ_BITS'(`CSR_OFS_RAM_EN):
				usiRd <= {{(`USI_BUS_WIDTH-1){1'b0}}, ramEn};
			`CSR_READ_BITS'(`CSR_OFS_RAM_RDY):
				usiRd <= {{(`USI_BUS_WIDTH-1){1'b0}}, ramRdySmp};
			// Unmapped offsets pass the write data along the chain
			default:
				usiRd <= usiWd;
		endcase
	end

endmodule

//--- UsiBusMaster.sv
`timescale 1ns/1ps

`include "usiRam_params.svh"

module UsiBusMaster
(
	input logic iSCLK,
	input logic iSRST,
	// Host command strobe
	input logic cmdValid,
	input usiPkg::cmdKindT cmdKind,
	input logic [15:0] cmdOfs,
	input logic [`USI_BUS_WIDTH-1:0] cmdWd,
	// USI bus
	output usiPkg::usiAdrsU usiAdrs,
	output logic [`USI_BUS_WIDTH-1:0] usiWd,
	input logic [`USI_BUS_WIDTH-1:0] usiRd,
	// Read response
	output logic rspValid,
	output logic [`USI_BUS_WIDTH-1:0] rspRd
);

	import usiPkg::*;

	// Bus word for the command being sampled
	usiAdrsU nextAdrs;
	// Pending read, one bit per pipeline stage
	logic [1:0] pendRd;

	// ------------------------------------------------
	// Command to bus word
	// ------------------------------------------------
	always_comb
	begin
		nextAdrs = '0;
		nextAdrs.fields.wrFlag = (cmdKind == CMD_WRITE);
		nextAdrs.fields.blockId = `CSR_BLOCK_ID;
		nextAdrs.fields.csrOfs = cmdOfs;
	end

	// Word lives on the bus for one cycle only
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
			usiAdrs <= '0;
		else if (cmdValid)
			usiAdrs <= nextAdrs;
		else
			usiAdrs <= '0;
	end

	// Write data, also the pass-through value of reads
	always_ff @(posedge iSCLK)
	begin
		if (cmdValid)
			usiWd <= cmdWd;
		else
			usiWd <= '0;
	end

	// ------------------------------------------------
	// Read response
	// ------------------------------------------------

	// Stage 0 marks the bus cycle, stage 1 the cycle usiRd is valid
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			pendRd <= 2'b00;
			rspValid <= 1'b0;
		end
		else
		begin
			pendRd <= {pendRd[0], cmdValid & (cmdKind == CMD_READ)};
			rspValid <= pendRd[1];
		end
	end

	// Capture CSR answer
	always_ff @(posedge iSCLK)
	begin
		if (pendRd[1])
			rspRd <= usiRd;
	end

endmodule

//--- usiPkg.sv
`include "usiRam_params.svh"

package usiPkg;

	// ------------------------------------------------
	// Address word of the USI bus
	// ------------------------------------------------

	// Field layout, MSB first
	typedef struct packed
	{
		// Bit 31, unused
		logic rsvdTop;
		// Bit 30, set on writes
		logic wrFlag;
		// Bits 29 to 24, unused
		logic [5:0] rsvd;
		// Target block number
		logic [7:0] blockId;
		// Register offset inside the block
		logic [15:0] csrOfs;
	} usiAdrsFieldsT;

	// Same word seen raw or split into fields
	typedef union packed
	{
		logic [`USI_BUS_WIDTH-1:0] raw;
		usiAdrsFieldsT fields;
	} usiAdrsU;

	// Host command kind
	typedef enum logic
	{
		CMD_READ = 1'b0,
		CMD_WRITE = 1'b1
	} cmdKindT;

endpackage

//--- usiRam_params.svh
`ifndef USI_RAM_PARAMS_SVH
`define USI_RAM_PARAMS_SVH

// ------------------------------------------------
// USI register bus
// ------------------------------------------------

// Data and address width of the bus
`define USI_BUS_WIDTH 32

// Block number of the microcontroller CSR
`define CSR_BLOCK_ID 8'h06

// ------------------------------------------------
// CSR register map
// ------------------------------------------------
`define CSR_OFS_RAM_WD 16'h0000
`define CSR_OFS_RAM_ADRS 16'h0004
`define CSR_OFS_RAM_EN 16'h0008
`define CSR_OFS_RAM_RDY 16'h0040

// Low offset bits seen by the read decode
`define CSR_READ_BITS 8

// ------------------------------------------------
// RAM side
// ------------------------------------------------
`define RAM_WD_WIDTH 16
`define RAM_ADRS_WIDTH 32

// 256 words, only the low address bits reach the array
`define MEM_ADRS_BITS 8

// Busy cycles per write
`define RAM_WRITE_CYCLES 3

`endif
